//--- capture_pkg.sv
`default_nettype none

package capture_pkg;

    // widths used throughout the capture path
    localparam int addr_width = 30;
    localparam int beat_width = 32;
    localparam int word_width = 64;

    typedef logic [addr_width-1:0] app_addr_t;     // memory address, byte units
    typedef logic [beat_width-1:0] beat_t;         // one application-port beat
    typedef logic [word_width-1:0] sample_word_t;  // low half goes out first

    // application port command codes
    typedef enum logic [2:0] {
        cmd_write = 3'd0,
        cmd_read  = 3'd1
    } app_cmd_t;

    typedef enum logic [2:0] {
        st_idle       = 3'd0,
        st_write_lo   = 3'd1,
        st_write_hi   = 3'd2,
        st_wait_read  = 3'd3,
        st_read_cmd   = 3'd4,
        st_read_gap   = 3'd5,
        st_wait_write = 3'd6,
        st_bypass     = 3'd7
    } capture_state_t;

    // requests from the sequencer to the address counter
    typedef enum logic [2:0] {
        op_hold              = 3'd0,
        op_restart           = 3'd1,
        op_restart_mark_here = 3'd2,  // end of data is the current address
        op_restart_mark_next = 3'd3,  // end of data is one step past current
        op_advance           = 3'd4
    } addr_op_t;

    // toward the memory controller
    typedef struct packed {
        app_addr_t addr;
        app_cmd_t  cmd;
        logic      en;
        beat_t     wdf_data;
        logic      wdf_end;
        logic      wdf_wren;
    } app_req_t;

    // back from the memory controller
    typedef struct packed {
        beat_t rd_data;
        logic  rd_data_end;
        logic  rd_data_valid;
        logic  rdy;
        logic  wdf_rdy;
    } app_rsp_t;

endpackage

`default_nettype wire

//--- addr_counter.sv
`timescale 1ns/1ns
`default_nettype none

module addr_counter import capture_pkg::*; #(
    parameter app_addr_t ADDR_INC = 30'd8,
    parameter app_addr_t ADDR_MAX = 30'h3FFF_FFF8
) (
    input  wire logic ui_clk,
    input  wire logic reset,
    input  addr_op_t  addr_op,
    output app_addr_t addr,
    output logic      read_done,
    output logic      mem_full
);

    app_addr_t top_addr;  // first address past the stored data

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            addr     <= '0;
            top_addr <= '0;
            mem_full <= 1'b0;
        end else begin
            case (addr_op)
                op_restart: begin
                    addr <= '0;
                end
                op_restart_mark_here: begin
                    // last beat pair already advanced past its slot
                    top_addr <= addr;
                    addr     <= '0;
                end
                op_restart_mark_next: begin
                    // final word sits at addr, count it in
                    top_addr <= addr + ADDR_INC;
                    addr     <= '0;
                end
                op_advance: begin
                    if (addr == ADDR_MAX)
                        mem_full <= 1'b1;  // sticky, address stays put
                    else
                        addr <= addr + ADDR_INC;
                end
                default: begin
                end
            endcase
        end
    end

    // readback is complete once the read pointer catches the mark
    assign read_done = (addr == top_addr);

endmodule

`default_nettype wire

//--- capture_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module capture_sequencer import capture_pkg::*; (
    input  wire logic          ui_clk,
    input  wire logic          reset,
    input  wire logic          capture_go,
    input  wire logic          write_done,
    input  wire logic          mem_ready,
    input  wire logic          use_mem,
    input  sample_word_t       pre_dout,
    input  wire logic          pre_empty,
    input  wire logic          post_full,
    input  wire logic          post_prog_full,
    input  app_rsp_t           app_rsp,
    input  wire logic          read_done,
    input  wire logic          post_wr,
    output logic               pre_rd,
    output app_cmd_t           cmd,
    output logic               en,
    output beat_t              wdf_data,
    output logic               wdf_end,
    output logic               wdf_wren,
    output addr_op_t           addr_op,
    output capture_state_t     state
);

    capture_state_t next_state;

    logic done_hold;     // write_done seen during this capture
    logic write_finish;  // done_hold and pre FIFO drained
    logic abort_req;     // capture_go arrived while busy
    logic pre_rd_r;
    logic writing;
    logic go_idle;

    assign writing = (state == st_wait_write) || (state == st_write_lo) ||
                     (state == st_write_hi);
    assign go_idle = capture_go || abort_req;

    assign cmd = writing ? cmd_write : cmd_read;

    // beat select, low half first
    always_comb begin
        case (state)
            st_write_lo: wdf_data = pre_dout[31:0];
            st_write_hi: wdf_data = pre_dout[63:32];
            default:     wdf_data = '0;
        endcase
    end

    always_comb begin
        next_state = state;
        en         = 1'b0;
        wdf_wren   = 1'b0;
        wdf_end    = 1'b0;
        pre_rd     = 1'b0;
        addr_op    = op_hold;

        case (state)
            st_idle: begin
                if (capture_go) begin
                    if (!use_mem) begin
                        next_state = st_bypass;
                    end else if (mem_ready) begin
                        addr_op    = op_restart;
                        next_state = st_wait_write;
                    end
                end
            end

            st_bypass: begin
                if (use_mem) begin
                    next_state = st_idle;
                end else if (!pre_empty && !post_full && !pre_rd_r && !post_wr) begin
                    pre_rd = 1'b1;  // at most one word in flight
                end
            end

            st_wait_write: begin
                if (go_idle) begin
                    next_state = st_idle;
                end else if (write_finish) begin
                    addr_op    = op_restart_mark_here;
                    next_state = st_wait_read;
                end else if (app_rsp.rdy && app_rsp.wdf_rdy && !pre_empty) begin
                    pre_rd     = 1'b1;  // fwft, word stays on pre_dout
                    next_state = st_write_lo;
                end
            end

            st_write_lo: begin
                en       = 1'b1;
                wdf_wren = 1'b1;
                if (app_rsp.rdy && app_rsp.wdf_rdy)
                    next_state = st_write_hi;
            end

            st_write_hi: begin
                wdf_wren = 1'b1;
                wdf_end  = 1'b1;
                if (app_rsp.wdf_rdy) begin
                    if (write_finish) begin
                        addr_op    = op_restart_mark_next;
                        next_state = st_wait_read;
                    end else begin
                        addr_op = op_advance;
                        if (app_rsp.rdy && !pre_empty) begin
                            pre_rd     = 1'b1;  // chain straight into the next word
                            next_state = st_write_lo;
                        end else begin
                            next_state = st_wait_write;
                        end
                    end
                end
            end

            st_wait_read: begin
                if (go_idle)
                    next_state = st_idle;
                else if (read_done)
                    next_state = st_idle;  // nothing was stored
                else if (app_rsp.rdy && !post_prog_full)
                    next_state = st_read_cmd;
            end

            st_read_cmd: begin
                en = 1'b1;
                if (app_rsp.rdy) begin
                    addr_op    = op_advance;
                    next_state = st_read_gap;
                end
            end

            st_read_gap: begin
                if (go_idle)
                    next_state = st_idle;
                else if (read_done)
                    next_state = st_idle;
                else if (app_rsp.rdy && !post_prog_full)
                    next_state = st_read_cmd;
                else
                    next_state = st_wait_read;  // throttled by post FIFO
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge ui_clk) begin
        if (reset) begin
            state        <= st_idle;
            pre_rd_r     <= 1'b0;
            done_hold    <= 1'b0;
            write_finish <= 1'b0;
            abort_req    <= 1'b0;
        end else begin
            state    <= next_state;
            pre_rd_r <= pre_rd;

            if (state == st_idle) begin
                done_hold    <= 1'b0;
                write_finish <= 1'b0;
                abort_req    <= 1'b0;
            end else begin
                if (write_done)
                    done_hold <= 1'b1;
                if (done_hold && pre_empty)
                    write_finish <= 1'b1;
                // remember a restart seen in a busy state
                if (capture_go && state != st_bypass)
                    abort_req <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- readback_assembler.sv
`timescale 1ns/1ns
`default_nettype none

module readback_assembler import capture_pkg::*; (
    input  wire logic    ui_clk,
    input  wire logic    reset,
    input  app_rsp_t     app_rsp,
    input  wire logic    bypass_rd,
    input  wire logic    bypass,
    input  sample_word_t pre_dout,
    output sample_word_t post_din,
    output logic         post_wr
);

    beat_t first_beat;  // low half, waits for its partner
    logic  first_valid;
    logic  last_valid;

    assign first_valid = app_rsp.rd_data_valid && !app_rsp.rd_data_end;
    assign last_valid  = app_rsp.rd_data_valid && app_rsp.rd_data_end;

    // write strobe toward the post FIFO
    always_ff @(posedge ui_clk) begin
        if (reset)
            post_wr <= 1'b0;
        else if (bypass)
            post_wr <= bypass_rd;  // one cycle behind the pop
        else
            post_wr <= last_valid;
    end

    // payload path
    always_ff @(posedge ui_clk) begin
        if (!bypass && first_valid)
            first_beat <= app_rsp.rd_data;

        if (bypass) begin
            if (bypass_rd)
                post_din <= pre_dout;  // word under the pop
        end else if (last_valid) begin
            post_din <= {app_rsp.rd_data, first_beat};
        end
    end

endmodule

`default_nettype wire

//--- capture_top.sv
`timescale 1ns/1ns
`default_nettype none

module capture_top import capture_pkg::*; #(
    parameter app_addr_t ADDR_INC = 30'd8,
    parameter app_addr_t ADDR_MAX = 30'h3FFF_FFF8
) (
    input  wire logic      ui_clk,
    input  wire logic      reset,
    input  wire logic      capture_go,
    input  wire logic      write_done,
    input  wire logic      mem_ready,       // calibration complete
    input  wire logic      use_mem,
    input  sample_word_t   pre_dout,
    input  wire logic      pre_empty,
    input  wire logic      post_full,
    input  wire logic      post_prog_full,
    input  app_rsp_t       app_rsp,
    output logic           pre_rd,
    output sample_word_t   post_din,
    output logic           post_wr,
    output app_req_t       app_req,
    output capture_state_t capture_state,
    output logic           mem_full
);

    app_addr_t mem_addr;
    app_cmd_t  seq_cmd;
    logic      seq_en;
    beat_t     seq_wdf_data;
    logic      seq_wdf_end;
    logic      seq_wdf_wren;
    addr_op_t  addr_op;
    logic      read_done;

    capture_sequencer i_sequencer (
        .ui_clk         (ui_clk),
        .reset          (reset),
        .capture_go     (capture_go),
        .write_done     (write_done),
        .mem_ready      (mem_ready),
        .use_mem        (use_mem),
        .pre_dout       (pre_dout),
        .pre_empty      (pre_empty),
        .post_full      (post_full),
        .post_prog_full (post_prog_full),
        .app_rsp        (app_rsp),
        .read_done      (read_done),
        .post_wr        (post_wr),
        .pre_rd         (pre_rd),
        .cmd            (seq_cmd),
        .en             (seq_en),
        .wdf_data       (seq_wdf_data),
        .wdf_end        (seq_wdf_end),
        .wdf_wren       (seq_wdf_wren),
        .addr_op        (addr_op),
        .state          (capture_state)
    );

    addr_counter #(
        .ADDR_INC (ADDR_INC),
        .ADDR_MAX (ADDR_MAX)
    ) i_addr_counter (
        .ui_clk    (ui_clk),
        .reset     (reset),
        .addr_op   (addr_op),
        .addr      (mem_addr),
        .read_done (read_done),
        .mem_full  (mem_full)
    );

    readback_assembler i_assembler (
        .ui_clk    (ui_clk),
        .reset     (reset),
        .app_rsp   (app_rsp),
        .bypass_rd (pre_rd),
        .bypass    (!use_mem),
        .pre_dout  (pre_dout),
        .post_din  (post_din),
        .post_wr   (post_wr)
    );

    // address comes from the counter, the rest from the FSM
    always_comb begin
        app_req.addr     = mem_addr;
        app_req.cmd      = seq_cmd;
        app_req.en       = seq_en;
        app_req.wdf_data = seq_wdf_data;
        app_req.wdf_end  = seq_wdf_end;
        app_req.wdf_wren = seq_wdf_wren;
    end

endmodule

`default_nettype wire

//--- tb_capture_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module tb_capture_assertions import capture_pkg::*; (
    input wire logic   ui_clk,
    input wire logic   reset,
    input wire logic   capture_go,
    input wire logic   use_mem,
    input wire logic   pre_rd,
    input wire logic   post_wr,
    input wire logic   post_full,
    input app_req_t    app_req,
    input sample_word_t pre_dout,
    input sample_word_t post_din
);

    int   error_count = 0;
    logic go_seen;

    always_ff @(posedge ui_clk) begin
        if (reset)
            go_seen <= 1'b0;
        else if (capture_go)
            go_seen <= 1'b1;
    end

    // nothing moves before the first capture_go
    quiet_until_go: assert property (@(posedge ui_clk) disable iff (reset)
        !go_seen |-> !(pre_rd || post_wr || app_req.en || app_req.wdf_wren))
    else begin
        error_count++;
        $error("activity before first capture_go");
    end

    bypass_word: assert property (@(posedge ui_clk) disable iff (reset)
        (!use_mem && post_wr) |-> ($past(pre_rd) && post_din == $past(pre_dout)))
    else begin
        error_count++;
        $error("bypass word does not follow its pop");
    end

    bypass_no_full: assert property (@(posedge ui_clk) disable iff (reset)
        (!use_mem && pre_rd) |-> !post_full)
    else begin
        error_count++;
        $error("pre_rd while post FIFO full");
    end

    bypass_spacing: assert property (@(posedge ui_clk) disable iff (reset)
        (!use_mem && pre_rd) |=> !pre_rd)
    else begin
        error_count++;
        $error("back to back pre_rd in bypass");
    end

endmodule

bind capture_top tb_capture_assertions i_checks (.*);

`default_nettype wire

//--- tb_app_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_app_mem import capture_pkg::*; (
    input  wire logic ui_clk,
    input  wire logic reset,
    input  app_req_t  app_req,
    output app_rsp_t  app_rsp
);

    integer seed = 44171;
    integer cyc  = 0;

    beat_t     lo_mem [app_addr_t];  // first beat of each word
    beat_t     hi_mem [app_addr_t];
    app_addr_t rd_addr_q [$];
    integer    rd_due_q [$];         // cycle of the first returned beat

    initial app_rsp = '0;

    // accept beats and read commands on the rising edge
    always @(posedge ui_clk) begin
        cyc = cyc + 1;
        if (!reset) begin
            if (app_req.wdf_wren && app_rsp.wdf_rdy) begin
                if (app_req.wdf_end)
                    hi_mem[app_req.addr] = app_req.wdf_data;
                else
                    lo_mem[app_req.addr] = app_req.wdf_data;
            end
            if (app_req.en && app_rsp.rdy && app_req.cmd == cmd_read) begin
                rd_addr_q.push_back(app_req.addr);
                rd_due_q.push_back(cyc + 2);
            end
        end
    end

    // responses change on the falling edge
    always @(negedge ui_clk) begin
        app_rsp.rdy           = ($random(seed) & 3) != 0;  // stall about 1 in 4
        app_rsp.wdf_rdy       = ($random(seed) & 3) != 0;
        app_rsp.rd_data_valid = 1'b0;
        app_rsp.rd_data_end   = 1'b0;
        app_rsp.rd_data       = '0;
        if (rd_due_q.size() > 0) begin
            if (cyc + 1 == rd_due_q[0]) begin
                app_rsp.rd_data_valid = 1'b1;
                app_rsp.rd_data       = lo_mem[rd_addr_q[0]];
            end else if (cyc == rd_due_q[0]) begin
                app_rsp.rd_data_valid = 1'b1;
                app_rsp.rd_data_end   = 1'b1;
                app_rsp.rd_data       = hi_mem[rd_addr_q.pop_front()];
                void'(rd_due_q.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_capture.sv
`timescale 1ns/1ns
`default_nettype none

module tb_capture import capture_pkg::*; ();

    logic           ui_clk = 1'b0;
    logic           reset;
    logic           capture_go;
    logic           write_done;
    logic           mem_ready;
    logic           use_mem;
    sample_word_t   pre_dout;
    logic           pre_empty;
    logic           post_full;
    logic           post_prog_full;
    app_rsp_t       app_rsp;
    logic           pre_rd;
    sample_word_t   post_din;
    logic           post_wr;
    app_req_t       app_req;
    capture_state_t capture_state;
    logic           mem_full;

    // second instance with a tiny address range for the full flag
    logic           full_go;
    integer         full_cnt;
    logic           full_pre_rd;
    app_req_t       full_req;
    app_rsp_t       full_rsp;
    logic           full_mem_full;

    integer       seed = 44171;
    sample_word_t pre_q [$];
    sample_word_t exp_q [$];
    sample_word_t held_word;   // last popped word, seen by the write path
    logic         pop_pend;
    logic         full_pop_pend;
    integer       rx_count;
    app_addr_t    waddr_exp;
    integer       i;

    always #50 ui_clk = ~ui_clk;

    capture_top i_dut (
        .ui_clk, .reset, .capture_go, .write_done, .mem_ready, .use_mem,
        .pre_dout, .pre_empty, .post_full, .post_prog_full, .app_rsp,
        .pre_rd, .post_din, .post_wr, .app_req, .capture_state, .mem_full
    );

    tb_app_mem i_mem (.ui_clk(ui_clk), .reset(reset), .app_req(app_req), .app_rsp(app_rsp));

    capture_top #(.ADDR_MAX(30'd40)) i_dut_full (
        .ui_clk(ui_clk), .reset(reset), .capture_go(full_go), .write_done(1'b0),
        .mem_ready(1'b1), .use_mem(1'b1), .pre_dout('0), .pre_empty(full_cnt == 0),
        .post_full(1'b0), .post_prog_full(1'b1), .app_rsp(full_rsp),
        .pre_rd(full_pre_rd), .post_din(), .post_wr(),
        .app_req(full_req), .capture_state(), .mem_full(full_mem_full)
    );

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        fail_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
            fail_run();
        end
    endtask

    task automatic load_words(input integer n);
        sample_word_t w;
        for (int k = 0; k < n; k++) begin
            w = {$random(seed), $random(seed)};
            pre_q.push_back(w);
            exp_q.push_back(w);
        end
    endtask

    task automatic pulse_go();
        @(negedge ui_clk) capture_go = 1'b1;
        @(negedge ui_clk) capture_go = 1'b0;
    endtask

    task automatic start_capture();
        waddr_exp = '0;  // every capture writes from address 0
        pulse_go();
        write_done = 1'b1;
        @(negedge ui_clk) write_done = 1'b0;
    endtask

    task automatic wait_rx(input integer n, input integer limit);
        for (int k = 0; k < limit && rx_count < n; k++)
            @(negedge ui_clk);
        if (rx_count < n)
            report_error("timeout waiting for post FIFO words");
    endtask

    task automatic wait_state(input capture_state_t s, input integer limit);
        for (int k = 0; k < limit && capture_state != s; k++)
            @(negedge ui_clk);
        if (capture_state != s)
            report_error($sformatf("timeout waiting for state %s", s.name()));
    endtask

    // FIFO models, flags and data change on the falling edge
    always @(negedge ui_clk) begin
        if (pop_pend)
            held_word = pre_q.pop_front();
        pop_pend = 1'b0;
        if (full_pop_pend)
            full_cnt = full_cnt - 1;
        full_pop_pend = 1'b0;
        pre_empty = (pre_q.size() == 0);
        if (use_mem || pre_q.size() == 0)
            pre_dout = held_word;
        else
            pre_dout = pre_q[0];  // first word fall through in bypass
    end

    always @(posedge ui_clk) begin : monitor
        sample_word_t expected_word;
        if (!reset) begin
            if (pre_rd) begin
                if (pre_q.size() == 0)
                    report_error("pre FIFO read while empty");
                pop_pend = 1'b1;
            end
            if (full_pre_rd)
                full_pop_pend = 1'b1;
            if (post_wr) begin
                if (exp_q.size() == 0)
                    report_error("post FIFO write with no word expected");
                expected_word = exp_q.pop_front();
                check_value("post_din", expected_word, post_din);
                rx_count++;
            end
            if (app_req.en && app_rsp.rdy && app_rsp.wdf_rdy && app_req.cmd == cmd_write) begin
                check_value("app_req.addr", waddr_exp, app_req.addr);
                waddr_exp = waddr_exp + 30'd8;
            end
            if (app_req.en && app_rsp.rdy && app_req.cmd == cmd_read && post_prog_full)
                report_error("read command accepted while post FIFO almost full");
        end
    end

    // concurrent checks raise their count, stop here
    always @(negedge ui_clk) begin
        if (i_dut.i_checks.error_count != 0 || i_dut_full.i_checks.error_count != 0)
            report_error("concurrent assertion failed");
    end

    initial begin
        reset = 1'b1;
        capture_go = 1'b0;
        write_done = 1'b0;
        mem_ready = 1'b1;
        use_mem = 1'b1;
        post_full = 1'b0;
        post_prog_full = 1'b0;
        pre_dout = '0;
        pre_empty = 1'b1;
        held_word = '0;
        pop_pend = 1'b0;
        full_pop_pend = 1'b0;
        full_go = 1'b0;
        full_cnt = 0;
        full_rsp = '0;
        full_rsp.rdy = 1'b1;
        full_rsp.wdf_rdy = 1'b1;
        rx_count = 0;
        waddr_exp = '0;
        repeat (3) @(negedge ui_clk);
        reset = 1'b0;
        repeat (6) @(negedge ui_clk);  // quiet idle stretch
        check_value("capture_state", st_idle, capture_state);

        // round trip of 20 words
        load_words(20);
        @(negedge ui_clk);
        start_capture();
        wait_rx(20, 3000);
        wait_state(st_idle, 200);
        repeat (5) @(negedge ui_clk);
        check_value("rx_count", 20, rx_count);
        check_value("mem_full", 0, mem_full);  // default range is far from full

        // readback held off by prog full
        rx_count = 0;
        post_prog_full = 1'b1;
        load_words(12);
        @(negedge ui_clk);
        start_capture();
        wait_state(st_wait_read, 3000);
        repeat (40) @(negedge ui_clk);
        check_value("rx_count", 0, rx_count);
        post_prog_full = 1'b0;
        wait_rx(12, 3000);
        wait_state(st_idle, 200);

        // bypass with post FIFO full toggling
        repeat (5) @(negedge ui_clk);
        use_mem = 1'b0;
        rx_count = 0;
        load_words(10);
        @(negedge ui_clk);
        pulse_go();
        for (i = 0; i < 2000 && rx_count < 10; i++) begin
            @(negedge ui_clk);
            post_full = (i % 7) > 4;
        end
        if (rx_count < 10)
            report_error("timeout waiting for bypass words");
        post_full = 1'b0;
        repeat (3) @(negedge ui_clk);
        use_mem = 1'b1;
        wait_state(st_idle, 20);

        // sticky full flag on the small instance
        check_value("mem_full", 0, full_mem_full);
        full_cnt = 8;
        @(negedge ui_clk) full_go = 1'b1;
        @(negedge ui_clk) full_go = 1'b0;
        for (i = 0; i < 200 && full_cnt != 0; i++)
            @(negedge ui_clk);
        if (full_cnt != 0)
            report_error("timeout waiting for words on the small instance");
        repeat (10) @(negedge ui_clk);
        check_value("mem_full", 1, full_mem_full);
        check_value("app_req.addr", 30'd40, full_req.addr);  // parked at the limit

        // abort during readback, then restart
        rx_count = 0;
        load_words(20);
        @(negedge ui_clk);
        start_capture();
        wait_state(st_read_gap, 3000);
        pulse_go();
        wait_state(st_idle, 10);  // far too short for the rest of the readback
        repeat (10) @(negedge ui_clk);  // let reads in flight land
        exp_q.delete();
        rx_count = 0;
        load_words(4);
        @(negedge ui_clk);
        start_capture();
        wait_rx(4, 2000);
        wait_state(st_idle, 200);
        repeat (5) @(negedge ui_clk);
        check_value("mem_full", 1, full_mem_full);

        if (i_dut.i_checks.error_count == 0 && i_dut_full.i_checks.error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
capture_pkg.sv
addr_counter.sv
capture_sequencer.sv
readback_assembler.sv
capture_top.sv
tb_capture_assertions.sv
tb_app_mem.sv
tb_capture.sv
